// File: src/exe_config.svh
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// datapath sizing for the execute stage

// data and address width
`define EXE_XLEN 32

// register number width
`define EXE_REG_W 5

// immediate field width
`define EXE_IMM_W 16

// shift amount width
`define EXE_SA_W 5

`endif

// File: src/exe_pkg.sv
`default_nettype none

package exe_pkg;

    // instructions accepted by the stage
    typedef enum logic [4:0] {
        op_add,   op_addu,  op_sub,   op_subu,
        op_addi,  op_addiu,
        op_and,   op_or,    op_xor,   op_nor,
        op_andi,  op_ori,
        op_slt,   op_sltu,
        op_sll,   op_srl,   op_sra,   op_lui,
        op_mult,  op_multu,
        op_mfhi,  op_mflo,  op_mthi,  op_mtlo,
        op_lw,    op_lh,    op_lb,
        op_sw,    op_sh,    op_sb
    } exe_op_t;

    // alu function
    typedef enum logic [3:0] {
        alu_add,  alu_sub,
        alu_and,  alu_or,   alu_xor,  alu_nor,
        alu_slt,  alu_sltu,
        alu_sll,  alu_srl,  alu_sra,
        alu_lui
    } alu_op_t;

    typedef enum logic {src1_rs, src1_sa} src1_sel_t;

    typedef enum logic [1:0] {src2_rt, src2_simm, src2_zimm} src2_sel_t;

    typedef enum logic [2:0] {
        mem_none, mem_lw, mem_lh, mem_lb, mem_sw, mem_sh, mem_sb
    } mem_kind_t;

    typedef enum logic [2:0] {
        hilo_none, hilo_mult, hilo_multu, hilo_mthi, hilo_mtlo, hilo_mfhi, hilo_mflo
    } hilo_act_t;

    // adel and ades are address errors on load and store
    typedef enum logic [1:0] {exc_none, exc_ovf, exc_adel, exc_ades} exc_code_t;

endpackage

`default_nettype wire

// File: src/exe_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_decode
    import exe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  exe_op_t               in_op,
    input  logic [`EXE_XLEN-1:0]  in_rs_value,
    input  logic [`EXE_XLEN-1:0]  in_rt_value,
    input  logic [`EXE_IMM_W-1:0] in_imm,
    input  logic [`EXE_SA_W-1:0]  in_sa,
    input  logic [`EXE_REG_W-1:0] in_dest,
    output logic                  de_valid,
    output alu_op_t               de_alu_op,
    output src1_sel_t             de_src1_sel,
    output src2_sel_t             de_src2_sel,
    output logic                  de_ovf_check,
    output mem_kind_t             de_mem_kind,
    output hilo_act_t             de_hilo_act,
    output logic                  de_gr_we,
    output logic [`EXE_XLEN-1:0]  de_rs_value,
    output logic [`EXE_XLEN-1:0]  de_rt_value,
    output logic [`EXE_IMM_W-1:0] de_imm,
    output logic [`EXE_SA_W-1:0]  de_sa,
    output logic [`EXE_REG_W-1:0] de_dest
);

    alu_op_t   alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    logic      ovf_check;
    mem_kind_t mem_kind;
    hilo_act_t hilo_act;
    logic      gr_we;

    // defaults describe a plain register-register alu op
    always_comb begin
        alu_op    = alu_add;
        src1_sel  = src1_rs;
        src2_sel  = src2_rt;
        ovf_check = 1'b0;
        mem_kind  = mem_none;
        hilo_act  = hilo_none;
        gr_we     = 1'b1;
        case (in_op)
            op_add, op_addu: ovf_check = (in_op == op_add);
            op_sub, op_subu: begin
                alu_op    = alu_sub;
                ovf_check = (in_op == op_sub);
            end
            op_addi, op_addiu: begin
                src2_sel  = src2_simm;
                ovf_check = (in_op == op_addi);
            end
            op_and:  alu_op = alu_and;
            op_or:   alu_op = alu_or;
            op_xor:  alu_op = alu_xor;
            op_nor:  alu_op = alu_nor;
            op_andi: begin
                alu_op   = alu_and;
                src2_sel = src2_zimm;
            end
            op_ori: begin
                alu_op   = alu_or;
                src2_sel = src2_zimm;
            end
            op_slt:  alu_op = alu_slt;
            op_sltu: alu_op = alu_sltu;
            op_sll, op_srl, op_sra: begin
                src1_sel = src1_sa;
                alu_op   = (in_op == op_sll) ? alu_sll :
                           (in_op == op_srl) ? alu_srl : alu_sra;
            end
            op_lui: begin
                alu_op   = alu_lui;
                src2_sel = src2_zimm;
            end
            op_mult, op_multu: begin
                hilo_act = (in_op == op_mult) ? hilo_mult : hilo_multu;
                gr_we    = 1'b0;
            end
            op_mfhi: hilo_act = hilo_mfhi;
            op_mflo: hilo_act = hilo_mflo;
            op_mthi, op_mtlo: begin
                hilo_act = (in_op == op_mthi) ? hilo_mthi : hilo_mtlo;
                gr_we    = 1'b0;
            end
            op_lw, op_lh, op_lb: begin
                src2_sel = src2_simm;
                mem_kind = (in_op == op_lw) ? mem_lw :
                           (in_op == op_lh) ? mem_lh : mem_lb;
            end
            op_sw, op_sh, op_sb: begin
                src2_sel = src2_simm;
                gr_we    = 1'b0;
                mem_kind = (in_op == op_sw) ? mem_sw :
                           (in_op == op_sh) ? mem_sh : mem_sb;
            end
            default: gr_we = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        de_alu_op    <= alu_op;
        de_src1_sel  <= src1_sel;
        de_src2_sel  <= src2_sel;
        de_ovf_check <= ovf_check;
        de_mem_kind  <= mem_kind;
        de_hilo_act  <= hilo_act;
        de_gr_we     <= gr_we;
        de_rs_value  <= in_rs_value;
        de_rt_value  <= in_rt_value;
        de_imm       <= in_imm;
        de_sa        <= in_sa;
        de_dest      <= in_dest;
    end

endmodule

`default_nettype wire

// File: src/exe_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_execute
    import exe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    de_valid,
    input  alu_op_t                 de_alu_op,
    input  src1_sel_t               de_src1_sel,
    input  src2_sel_t               de_src2_sel,
    input  logic                    de_ovf_check,
    input  mem_kind_t               de_mem_kind,
    input  hilo_act_t               de_hilo_act,
    input  logic                    de_gr_we,
    input  logic [`EXE_XLEN-1:0]    de_rs_value,
    input  logic [`EXE_XLEN-1:0]    de_rt_value,
    input  logic [`EXE_IMM_W-1:0]   de_imm,
    input  logic [`EXE_SA_W-1:0]    de_sa,
    input  logic [`EXE_REG_W-1:0]   de_dest,
    output logic                    ex_valid,
    output logic [`EXE_XLEN-1:0]    ex_alu_result,
    output logic [2*`EXE_XLEN-1:0]  ex_product,
    output exc_code_t               ex_exc,
    output mem_kind_t               ex_mem_kind,
    output hilo_act_t               ex_hilo_act,
    output logic                    ex_gr_we,
    output logic [`EXE_XLEN-1:0]    ex_rs_value,
    output logic [`EXE_XLEN-1:0]    ex_rt_value,
    output logic [`EXE_REG_W-1:0]   ex_dest
);

    localparam int MSB = `EXE_XLEN - 1;

    logic [`EXE_XLEN-1:0]   src1;
    logic [`EXE_XLEN-1:0]   src2;
    logic [`EXE_XLEN-1:0]   alu_result;
    logic                   sum_ovf;
    logic                   diff_ovf;
    logic                   ovf;
    logic                   adel;
    logic                   ades;
    exc_code_t              exc;
    logic signed [2*`EXE_XLEN-1:0] prod_s;
    logic [2*`EXE_XLEN-1:0] prod_u;

    assign src1 = (de_src1_sel == src1_sa) ? {{(`EXE_XLEN-`EXE_SA_W){1'b0}}, de_sa} : de_rs_value;

    always_comb begin
        case (de_src2_sel)
            src2_simm: src2 = {{(`EXE_XLEN-`EXE_IMM_W){de_imm[`EXE_IMM_W-1]}}, de_imm};
            src2_zimm: src2 = {{(`EXE_XLEN-`EXE_IMM_W){1'b0}}, de_imm};
            default:   src2 = de_rt_value;
        endcase
    end

    // shifts take the amount from src1 and shift src2
    always_comb begin
        case (de_alu_op)
            alu_add:  alu_result = src1 + src2;
            alu_sub:  alu_result = src1 - src2;
            alu_and:  alu_result = src1 & src2;
            alu_or:   alu_result = src1 | src2;
            alu_xor:  alu_result = src1 ^ src2;
            alu_nor:  alu_result = ~(src1 | src2);
            alu_slt:  alu_result = {{MSB{1'b0}}, $signed(src1) < $signed(src2)};
            alu_sltu: alu_result = {{MSB{1'b0}}, src1 < src2};
            alu_sll:  alu_result = src2 << src1[`EXE_SA_W-1:0];
            alu_srl:  alu_result = src2 >> src1[`EXE_SA_W-1:0];
            alu_sra:  alu_result = $signed(src2) >>> src1[`EXE_SA_W-1:0];
            alu_lui:  alu_result = {src2[`EXE_IMM_W-1:0], {(`EXE_XLEN-`EXE_IMM_W){1'b0}}};
            default:  alu_result = '0;
        endcase
    end

    // signed overflow of the trapping add and sub
    assign sum_ovf  = (src1[MSB] == src2[MSB]) && (alu_result[MSB] != src1[MSB]);
    assign diff_ovf = (src1[MSB] != src2[MSB]) && (alu_result[MSB] != src1[MSB]);
    assign ovf      = de_ovf_check && ((de_alu_op == alu_sub) ? diff_ovf : sum_ovf);

    always_comb begin
        adel = 1'b0;
        ades = 1'b0;
        case (de_mem_kind)
            mem_lw:  adel = (alu_result[1:0] != 2'b00);
            mem_lh:  adel = alu_result[0];
            mem_sw:  ades = (alu_result[1:0] != 2'b00);
            mem_sh:  ades = alu_result[0];
            default: adel = 1'b0;
        endcase
    end

    assign exc = ovf  ? exc_ovf  :
                 adel ? exc_adel :
                 ades ? exc_ades : exc_none;

    assign prod_s = $signed(de_rs_value) * $signed(de_rt_value);
    assign prod_u = de_rs_value * de_rt_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= de_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_result <= alu_result;
        ex_product    <= (de_hilo_act == hilo_mult) ? prod_s : prod_u;
        ex_exc        <= exc;
        ex_mem_kind   <= de_mem_kind;
        ex_hilo_act   <= de_hilo_act;
        ex_gr_we      <= de_gr_we;
        ex_rs_value   <= de_rs_value;
        ex_rt_value   <= de_rt_value;
        ex_dest       <= de_dest;
    end

endmodule

`default_nettype wire

// File: src/exe_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_result
    import exe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ex_valid,
    input  logic [`EXE_XLEN-1:0]    ex_alu_result,
    input  logic [2*`EXE_XLEN-1:0]  ex_product,
    input  exc_code_t               ex_exc,
    input  mem_kind_t               ex_mem_kind,
    input  hilo_act_t               ex_hilo_act,
    input  logic                    ex_gr_we,
    input  logic [`EXE_XLEN-1:0]    ex_rs_value,
    input  logic [`EXE_XLEN-1:0]    ex_rt_value,
    input  logic [`EXE_REG_W-1:0]   ex_dest,
    output logic                    out_valid,
    output logic [`EXE_XLEN-1:0]    out_result,
    output logic [`EXE_REG_W-1:0]   out_dest,
    output logic                    out_gr_we,
    output exc_code_t               out_exc,
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [`EXE_XLEN-1:0]    mem_addr,
    output logic [3:0]              mem_wstrb,
    output logic [`EXE_XLEN-1:0]    mem_wdata
);

    logic [`EXE_XLEN-1:0] hi;
    logic [`EXE_XLEN-1:0] lo;
    logic                 ok;
    logic                 is_store;
    logic [`EXE_XLEN-1:0] result;
    logic [`EXE_XLEN-1:0] st_data;
    logic [3:0]           st_strb;

    // valid and free of exceptions
    assign ok       = ex_valid && (ex_exc == exc_none);
    assign is_store = ex_mem_kind inside {mem_sw, mem_sh, mem_sb};

    // hi/lo live here so a move-from sees every earlier update
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (ok) begin
            if (ex_hilo_act == hilo_mult || ex_hilo_act == hilo_multu) begin
                hi <= ex_product[2*`EXE_XLEN-1:`EXE_XLEN];
                lo <= ex_product[`EXE_XLEN-1:0];
            end else if (ex_hilo_act == hilo_mthi) begin
                hi <= ex_rs_value;
            end else if (ex_hilo_act == hilo_mtlo) begin
                lo <= ex_rs_value;
            end
        end
    end

    assign result = (ex_hilo_act == hilo_mfhi) ? hi :
                    (ex_hilo_act == hilo_mflo) ? lo : ex_alu_result;

    // lane placement from the low address bits
    always_comb begin
        case (ex_mem_kind)
            mem_sb: begin
                st_data = {4{ex_rt_value[7:0]}};
                st_strb = 4'b0001 << ex_alu_result[1:0];
            end
            mem_sh: begin
                st_data = {2{ex_rt_value[15:0]}};
                st_strb = ex_alu_result[1] ? 4'b1100 : 4'b0011;
            end
            mem_sw: begin
                st_data = ex_rt_value;
                st_strb = 4'b1111;
            end
            default: begin
                st_data = ex_rt_value;
                st_strb = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_gr_we <= 1'b0;
            out_exc   <= exc_none;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
            mem_wstrb <= 4'b0000;
        end else begin
            out_valid <= ex_valid;
            out_gr_we <= ok && ex_gr_we;
            out_exc   <= ex_valid ? ex_exc : exc_none;
            mem_req   <= ok && (ex_mem_kind != mem_none);
            mem_we    <= ok && is_store;
            mem_wstrb <= (ok && is_store) ? st_strb : 4'b0000;
        end
    end

    // loads report the effective address as their result
    always_ff @(posedge clk) begin
        out_result <= result;
        out_dest   <= ex_dest;
        mem_addr   <= ex_alu_result;
        mem_wdata  <= st_data;
    end

endmodule

`default_nettype wire

// File: src/exe_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_stage_top
    import exe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  exe_op_t               in_op,
    input  logic [`EXE_XLEN-1:0]  in_rs_value,
    input  logic [`EXE_XLEN-1:0]  in_rt_value,
    input  logic [`EXE_IMM_W-1:0] in_imm,
    input  logic [`EXE_SA_W-1:0]  in_sa,
    input  logic [`EXE_REG_W-1:0] in_dest,
    output logic                  out_valid,
    output logic [`EXE_XLEN-1:0]  out_result,
    output logic [`EXE_REG_W-1:0] out_dest,
    output logic                  out_gr_we,
    output exc_code_t             out_exc,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [`EXE_XLEN-1:0]  mem_addr,
    output logic [3:0]            mem_wstrb,
    output logic [`EXE_XLEN-1:0]  mem_wdata
);

    // decode to execute
    logic                   de_valid;
    alu_op_t                de_alu_op;
    src1_sel_t              de_src1_sel;
    src2_sel_t              de_src2_sel;
    logic                   de_ovf_check;
    mem_kind_t              de_mem_kind;
    hilo_act_t              de_hilo_act;
    logic                   de_gr_we;
    logic [`EXE_XLEN-1:0]   de_rs_value;
    logic [`EXE_XLEN-1:0]   de_rt_value;
    logic [`EXE_IMM_W-1:0]  de_imm;
    logic [`EXE_SA_W-1:0]   de_sa;
    logic [`EXE_REG_W-1:0]  de_dest;

    // execute to result
    logic                   ex_valid;
    logic [`EXE_XLEN-1:0]   ex_alu_result;
    logic [2*`EXE_XLEN-1:0] ex_product;
    exc_code_t              ex_exc;
    mem_kind_t              ex_mem_kind;
    hilo_act_t              ex_hilo_act;
    logic                   ex_gr_we;
    logic [`EXE_XLEN-1:0]   ex_rs_value;
    logic [`EXE_XLEN-1:0]   ex_rt_value;
    logic [`EXE_REG_W-1:0]  ex_dest;

    // port names match the stage links one to one
    exe_decode  u_decode  (.*);
    exe_execute u_execute (.*);
    exe_result  u_result  (.*);

endmodule

`default_nettype wire

// File: sim/exe_tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module exe_tb_clock (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for four rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/exe_assert.sv
`timescale 1ns/1ps
`default_nettype none

module exe_assert
    import exe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       out_valid,
    input  logic       out_gr_we,
    input  exc_code_t  out_exc,
    input  logic       mem_req,
    input  logic       mem_we,
    input  logic [3:0] mem_wstrb
);

    strobe_needs_store: assert property (@(posedge clk) disable iff (reset)
        (mem_wstrb != 4'b0000) |-> (mem_req && mem_we))
        else $error("write strobe set without a store request");

    // a faulting instruction leaves no side effect
    exception_is_quiet: assert property (@(posedge clk) disable iff (reset)
        (out_exc != exc_none) |-> (!out_gr_we && !mem_req))
        else $error("faulting instruction still writes a register or requests memory");

    request_needs_valid: assert property (@(posedge clk) disable iff (reset)
        mem_req |-> out_valid)
        else $error("memory request without a valid result");

endmodule

bind exe_stage_top exe_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .out_valid (out_valid),
    .out_gr_we (out_gr_we),
    .out_exc   (out_exc),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_wstrb (mem_wstrb)
);

`default_nettype wire

// File: sim/exe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_tb
    import exe_pkg::*;
();

    localparam int XLEN           = `EXE_XLEN;
    localparam int SEED           = 66905;
    // about 150 instructions at up to 6 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct {
        logic [XLEN-1:0]       result;
        logic [`EXE_REG_W-1:0] dest;
        logic                  gr_we;
        exc_code_t             exc;
        logic                  req;
        logic                  we;
        logic [XLEN-1:0]       addr;
        logic [3:0]            strb;
        logic [XLEN-1:0]       wdata;
        int                    cycle;
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    exe_op_t               in_op;
    logic [XLEN-1:0]       in_rs_value;
    logic [XLEN-1:0]       in_rt_value;
    logic [`EXE_IMM_W-1:0] in_imm;
    logic [`EXE_SA_W-1:0]  in_sa;
    logic [`EXE_REG_W-1:0] in_dest;
    logic                  out_valid;
    logic [XLEN-1:0]       out_result;
    logic [`EXE_REG_W-1:0] out_dest;
    logic                  out_gr_we;
    exc_code_t             out_exc;
    logic                  mem_req;
    logic                  mem_we;
    logic [XLEN-1:0]       mem_addr;
    logic [3:0]            mem_wstrb;
    logic [XLEN-1:0]       mem_wdata;

    expect_t               exp_q[$];
    expect_t               head;
    logic [XLEN-1:0]       model_hi;
    logic [XLEN-1:0]       model_lo;
    int                    cycle = 0;
    int unsigned           seed_value;

    exe_tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    exe_stage_top UUT (.*);

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_exc(input exc_code_t got, input exc_code_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
            abort_run();
        end
    endtask

    task automatic check_strobe(input logic [3:0] got, input logic [3:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // reference model, hi/lo updated in program order
    task automatic predict(
        input  exe_op_t               op,
        input  logic [XLEN-1:0]       rs,
        input  logic [XLEN-1:0]       rt,
        input  logic [`EXE_IMM_W-1:0] imm,
        input  logic [`EXE_SA_W-1:0]  sa,
        input  logic [`EXE_REG_W-1:0] dest,
        output expect_t               e
    );
        logic [XLEN-1:0]   simm;
        logic [XLEN-1:0]   zimm;
        logic [XLEN:0]     wide;
        logic [2*XLEN-1:0] prod;
        simm    = {{(XLEN-`EXE_IMM_W){imm[`EXE_IMM_W-1]}}, imm};
        zimm    = {{(XLEN-`EXE_IMM_W){1'b0}}, imm};
        wide    = '0;
        e.result = '0;
        e.dest  = dest;
        e.gr_we = 1'b1;
        e.exc   = exc_none;
        e.req   = 1'b0;
        e.we    = 1'b0;
        e.addr  = '0;
        e.strb  = 4'b0000;
        e.wdata = '0;
        e.cycle = 0;
        case (op)
            op_add, op_addu, op_sub, op_subu, op_addi, op_addiu: begin
                // one extra sign bit exposes signed overflow
                if (op == op_sub || op == op_subu) begin
                    wide = {rs[XLEN-1], rs} - {rt[XLEN-1], rt};
                end else if (op == op_addi || op == op_addiu) begin
                    wide = {rs[XLEN-1], rs} + {simm[XLEN-1], simm};
                end else begin
                    wide = {rs[XLEN-1], rs} + {rt[XLEN-1], rt};
                end
                e.result = wide[XLEN-1:0];
                if ((op == op_add || op == op_sub || op == op_addi) &&
                    wide[XLEN] != wide[XLEN-1]) begin
                    e.exc = exc_ovf;
                end
            end
            op_and:  e.result = rs & rt;
            op_or:   e.result = rs | rt;
            op_xor:  e.result = rs ^ rt;
            op_nor:  e.result = ~(rs | rt);
            op_andi: e.result = rs & zimm;
            op_ori:  e.result = rs | zimm;
            op_slt:  e.result = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
            op_sltu: e.result = (rs < rt) ? 32'd1 : 32'd0;
            op_sll:  e.result = rt << sa;
            op_srl:  e.result = rt >> sa;
            op_sra:  e.result = $signed(rt) >>> sa;
            op_lui:  e.result = {imm, 16'h0000};
            op_mult, op_multu: begin
                if (op == op_mult) begin
                    prod = {{XLEN{rs[XLEN-1]}}, rs} * {{XLEN{rt[XLEN-1]}}, rt};
                end else begin
                    prod = {{XLEN{1'b0}}, rs} * {{XLEN{1'b0}}, rt};
                end
                model_hi = prod[2*XLEN-1:XLEN];
                model_lo = prod[XLEN-1:0];
                e.gr_we  = 1'b0;
            end
            op_mfhi: e.result = model_hi;
            op_mflo: e.result = model_lo;
            op_mthi, op_mtlo: begin
                if (op == op_mthi) begin
                    model_hi = rs;
                end else begin
                    model_lo = rs;
                end
                e.gr_we = 1'b0;
            end
            op_lw, op_lh, op_lb: begin
                e.addr   = rs + simm;
                e.result = e.addr;
                e.req    = 1'b1;
                if ((op == op_lw && e.addr[1:0] != 2'b00) || (op == op_lh && e.addr[0])) begin
                    e.exc = exc_adel;
                end
            end
            op_sw, op_sh, op_sb: begin
                e.addr  = rs + simm;
                e.req   = 1'b1;
                e.we    = 1'b1;
                e.gr_we = 1'b0;
                if (op == op_sw) begin
                    e.wdata = rt;
                    e.strb  = 4'b1111;
                end else if (op == op_sh) begin
                    e.wdata = {2{rt[15:0]}};
                    // the half sits in the lane pair picked by address bit 1
                    e.strb[{e.addr[1], 1'b0} +: 2] = 2'b11;
                end else begin
                    e.wdata = {4{rt[7:0]}};
                    e.strb[e.addr[1:0]] = 1'b1;
                end
                if ((op == op_sw && e.addr[1:0] != 2'b00) || (op == op_sh && e.addr[0])) begin
                    e.exc = exc_ades;
                end
            end
            default: e.gr_we = 1'b0;
        endcase
        if (e.exc != exc_none) begin
            e.gr_we = 1'b0;
            e.req   = 1'b0;
            e.we    = 1'b0;
            e.strb  = 4'b0000;
        end
    endtask

    // called 2 ns after a rising edge, returns 2 ns after the next one
    task automatic issue(input exe_op_t op, input logic [XLEN-1:0] rs,
                         input logic [XLEN-1:0] rt, input logic [`EXE_IMM_W-1:0] imm,
                         input logic [`EXE_SA_W-1:0] sa, input logic [`EXE_REG_W-1:0] dest);
        expect_t e;
        predict(op, rs, rt, imm, sa, dest, e);
        e.cycle = cycle + 3;
        exp_q.push_back(e);
        in_valid    = 1'b1;
        in_op       = op;
        in_rs_value = rs;
        in_rt_value = rt;
        in_imm      = imm;
        in_sa       = sa;
        in_dest     = dest;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic read_hilo(input logic [`EXE_REG_W-1:0] dest);
        issue(op_mfhi, '0, '0, '0, '0, dest);
        issue(op_mflo, '0, '0, '0, '0, dest + 5'd1);
    endtask

    task automatic quiet_after_reset();
        repeat (4) begin
            @(negedge clk);
            check_flag(out_valid, 1'b0, "out_valid after reset");
            check_flag(mem_req, 1'b0, "mem_req after reset");
            check_flag(out_gr_we, 1'b0, "out_gr_we after reset");
        end
        @(posedge clk);
        #2;
    endtask

    task automatic alu_ops_random();
        exe_op_t         ops[18];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] c;
        ops = '{op_add, op_addu, op_sub, op_subu, op_addi, op_addiu, op_and, op_or, op_xor,
                op_nor, op_andi, op_ori, op_slt, op_sltu, op_sll, op_srl, op_sra, op_lui};
        foreach (ops[i]) begin
            repeat (4) begin
                a = $urandom();
                b = $urandom();
                c = $urandom();
                issue(ops[i], a, b, c[15:0], c[20:16], c[25:21]);
            end
        end
        drain();
    endtask

    task automatic overflow_traps();
        issue(op_add,   32'h7fff_ffff, 32'h0000_0001, 16'h0000, 5'd0, 5'd1);
        issue(op_addu,  32'h7fff_ffff, 32'h0000_0001, 16'h0000, 5'd0, 5'd2);
        issue(op_add,   32'h8000_0000, 32'h8000_0000, 16'h0000, 5'd0, 5'd3);
        issue(op_sub,   32'h8000_0000, 32'h0000_0001, 16'h0000, 5'd0, 5'd4);
        issue(op_subu,  32'h8000_0000, 32'h0000_0001, 16'h0000, 5'd0, 5'd5);
        issue(op_sub,   32'h7fff_ffff, 32'hffff_ffff, 16'h0000, 5'd0, 5'd6);
        issue(op_addi,  32'h7fff_fff0, 32'h0000_0000, 16'h0010, 5'd0, 5'd7);
        issue(op_addiu, 32'h7fff_fff0, 32'h0000_0000, 16'h0010, 5'd0, 5'd8);
        issue(op_addi,  32'h8000_0000, 32'h0000_0000, 16'hffff, 5'd0, 5'd9);
        drain();
    endtask

    task automatic hilo_sequence();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        // hi and lo still hold their reset value here
        read_hilo(5'd8);
        issue(op_mult, 32'hffff_fffd, 32'h0000_0007, '0, '0, 5'd0);
        read_hilo(5'd10);
        issue(op_multu, 32'hffff_fffd, 32'h0000_0007, '0, '0, 5'd0);
        read_hilo(5'd12);
        a = $urandom();
        b = $urandom();
        issue(op_mthi, a, '0, '0, '0, 5'd0);
        issue(op_mtlo, b, '0, '0, '0, 5'd0);
        read_hilo(5'd14);
        a = $urandom();
        b = $urandom();
        issue(op_mult, a, b, '0, '0, 5'd0);
        read_hilo(5'd16);
        issue(op_multu, b, a, '0, '0, 5'd0);
        read_hilo(5'd18);
        drain();
    endtask

    task automatic store_lanes();
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] data;
        base = $urandom() & 32'hffff_fff0;
        for (int off = 0; off < 4; off++) begin
            data = $urandom();
            issue(op_sb, base, data, 16'(off), '0, 5'd0);
        end
        issue(op_sh, base, data, 16'd0, '0, 5'd0);
        issue(op_sh, base, data, 16'd2, '0, 5'd0);
        issue(op_sw, base, data, 16'd4, '0, 5'd0);
        issue(op_sw, base, data, 16'hfffc, '0, 5'd0);
        drain();
    endtask

    task automatic misaligned_access();
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] data;
        base = $urandom() & 32'hffff_fff0;
        data = $urandom();
        for (int off = 0; off < 4; off++) begin
            issue(op_lw, base, data, 16'(off), '0, 5'd20);
            issue(op_lh, base, data, 16'(off), '0, 5'd21);
            issue(op_lb, base, data, 16'(off), '0, 5'd22);
            issue(op_sw, base, data, 16'(off), '0, 5'd0);
            issue(op_sh, base, data, 16'(off), '0, 5'd0);
            issue(op_sb, base, data, 16'(off), '0, 5'd0);
        end
        drain();
    endtask

    task automatic mixed_burst();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] c;
        logic [XLEN-1:0] d;
        repeat (24) begin
            a = $urandom();
            b = $urandom();
            c = $urandom();
            d = $urandom();
            issue(exe_op_t'(5'(d % 30)), a, b, c[15:0], c[20:16], c[25:21]);
        end
        drain();
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // results leave in order, three cycles after issue
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid went high at %0t with no instruction in flight", $time);
                    abort_run();
                end
                head = exp_q.pop_front();
                if (cycle != head.cycle) begin
                    $display("Mismatch at %0t: result came in cycle %0d, expected %0d",
                             $time, cycle, head.cycle);
                    abort_run();
                end
                check_word(XLEN'(out_dest), XLEN'(head.dest), "destination");
                check_flag(out_gr_we, head.gr_we, "register write enable");
                check_exc(out_exc, head.exc, "exception code");
                check_flag(mem_req, head.req, "memory request");
                check_flag(mem_we, head.we, "memory write enable");
                check_strobe(mem_wstrb, head.strb, "write strobe");
                if (head.gr_we) begin
                    check_word(out_result, head.result, "result");
                end
                if (head.req) begin
                    check_word(mem_addr, head.addr, "memory address");
                end
                if (head.we) begin
                    check_word(mem_wdata, head.wdata, "store data");
                end
            end else begin
                check_flag(mem_req, 1'b0, "mem_req without out_valid");
                check_flag(out_gr_we, 1'b0, "out_gr_we without out_valid");
            end
        end
    end

    initial begin
        seed_value  = $urandom(SEED);
        in_valid    = 1'b0;
        in_op       = op_add;
        in_rs_value = '0;
        in_rt_value = '0;
        in_imm      = '0;
        in_sa       = '0;
        in_dest     = '0;
        model_hi    = '0;
        model_lo    = '0;
        wait (reset == 1'b0);
        quiet_after_reset();
        alu_ops_random();
        overflow_traps();
        hilo_sequence();
        store_lanes();
        misaligned_access();
        mixed_burst();
        if (exp_q.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("instructions still in flight at the end of the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/exe_pkg.sv
src/exe_decode.sv
src/exe_execute.sv
src/exe_result.sv
src/exe_stage_top.sv
sim/exe_tb_clock.sv
sim/exe_assert.sv
sim/exe_tb.sv

// File: Makefile
VERILATOR := verilator
TOP       := exe_tb
FILELIST  := files.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
